// ==== rtl/lab4_pkg.sv ====
package lab4_pkg;

	// width of one serial configuration word
	parameter int LAB4_REG_WIDTH = 24;

	// serial shift prescale width
	parameter int PRESCALE_WIDTH = 8;

	// select field width for a given number of LABs
	// a power of two count needs one extra bit so that all ones stays free
	// all ones always means every LAB
	function automatic int lab4_sel_width(input int num_labs);
		int lg;
		lg = $clog2(num_labs);
		if ((1 << lg) == num_labs)
			return lg + 1;
		return lg;
	endfunction

endpackage

// ==== rtl/lab4_regs_pkg.sv ====
package lab4_regs_pkg;

	//////////////////////////////////////////////////////////////////////
	// word indices, taken from wb address bits 6..2
	//////////////////////////////////////////////////////////////////////
	parameter logic [4:0] REG_CONTROL          = 5'd0;
	parameter logic [4:0] REG_SHIFT_PRESCALE   = 5'd1;
	parameter logic [4:0] REG_READOUT_PRESCALE = 5'd2;
	parameter logic [4:0] REG_USER_WRITE       = 5'd6;
	parameter logic [4:0] REG_TRIGGER          = 5'd21;
	parameter logic [4:0] REG_READOUT          = 5'd22;
	parameter logic [4:0] REG_EMPTY_THRESHOLD  = 5'd23;

	// field widths and reset values
	parameter int READOUT_PRESCALE_WIDTH = 4;
	parameter int EMPTY_SIZE_WIDTH       = 10;
	parameter int FORCE_COUNT_WIDTH      = 8;
	parameter logic [lab4_pkg::PRESCALE_WIDTH-1:0] SHIFT_PRESCALE_DEFAULT = 'd1;
	parameter logic [READOUT_PRESCALE_WIDTH-1:0] READOUT_PRESCALE_DEFAULT = 'd1;

	//////////////////////////////////////////////////////////////////////
	// bit positions
	//////////////////////////////////////////////////////////////////////
	parameter int CTRL_RESET_REQ      = 0;
	parameter int CTRL_RUNMODE_REQ    = 1;
	parameter int CTRL_TEST_PATTERN   = 15;
	parameter int CTRL_REGCLR         = 16;
	// user write word, select sits just above the data
	parameter int UW_SEL_LSB          = 24;
	parameter int UW_REQUEST          = 31;
	parameter int TRIG_FORCE          = 1;
	parameter int TRIG_COUNT_LSB      = 8;
	parameter int RD_FIFO_RST         = 1;
	parameter int RD_RST              = 2;
	parameter int RD_DATA_AVAIL       = 3;
	parameter int RD_NOT_TEST_PATTERN = 4;
	parameter int RD_FORCE_ACTIVE     = 5;
	parameter int RD_PENDING          = 7;
	parameter int RD_EMPTY_LSB        = 8;

endpackage

// ==== rtl/lab4_ifs.sv ====
`timescale 1ns/100ps

// serial write command from the register bank to the shift engine
// a go seen while busy is dropped by the writer
interface serial_cmd_if #(
	parameter int NUM_LABS = 4
) ();
	localparam int SEL_W = lab4_pkg::lab4_sel_width(NUM_LABS);

	logic go;
	logic [lab4_pkg::LAB4_REG_WIDTH-1:0] data;
	logic [SEL_W-1:0] sel;
	logic [lab4_pkg::PRESCALE_WIDTH-1:0] prescale;
	logic busy;

	modport ctrl (output go, output data, output sel, output prescale, input busy);
	modport writer (input go, input data, input sel, input prescale, output busy);
endinterface

// forced trigger request and sequencer status
interface readout_seq_if ();
	logic force_req;
	logic [lab4_regs_pkg::FORCE_COUNT_WIDTH-1:0] force_count;
	// pending is high between a strobe and its completion
	logic pending;
	logic active;

	modport ctrl (output force_req, output force_count, input pending, input active);
	modport seq (input force_req, input force_count, output pending, output active);
endinterface

// ==== rtl/lab4_reg_ctrl.sv ====
`timescale 1ns/100ps

module lab4_reg_ctrl #(
	parameter int NUM_LABS = 4
) (
	input  logic clk_i,
	input  logic arst_n_i,
	input  logic wb_cyc_i,
	input  logic wb_stb_i,
	input  logic wb_we_i,
	input  logic [6:0] wb_adr_i,
	input  logic [3:0] wb_sel_i,
	input  logic [31:0] wb_dat_i,
	output logic [31:0] wb_dat_o,
	output logic wb_ack_o,
	input  logic [NUM_LABS-1:0] readout_fifo_empty_i,
	output logic regclr_o,
	output logic readout_test_pattern_o,
	output logic readout_fifo_rst_o,
	output logic readout_rst_o,
	output logic [lab4_regs_pkg::EMPTY_SIZE_WIDTH-1:0] readout_empty_size_o,
	output logic [lab4_regs_pkg::READOUT_PRESCALE_WIDTH-1:0] prescale_o,
	serial_cmd_if.ctrl serial_cmd,
	readout_seq_if.ctrl ro_seq
);
	localparam int SEL_W = lab4_pkg::lab4_sel_width(NUM_LABS);
	localparam int DW = lab4_pkg::LAB4_REG_WIDTH;
	localparam int FCW = lab4_regs_pkg::FORCE_COUNT_WIDTH;

	logic wb_write;
	logic [4:0] word;
	logic reset_req;
	logic runmode_req;
	logic not_test_pattern;
	logic [lab4_pkg::PRESCALE_WIDTH-1:0] shift_prescale;
	logic [DW-1:0] uw_data;
	logic [SEL_W-1:0] uw_sel;
	logic go_q;
	logic force_q;
	logic [FCW-1:0] force_count;

	assign wb_write = wb_cyc_i & wb_stb_i & wb_we_i;
	assign word = wb_adr_i[6:2];

	//////////////////////////////////////////////////////////////////////
	// register writes and strobes
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wb_ack_o <= 1'b0;
			reset_req <= 1'b0;
			runmode_req <= 1'b0;
			readout_test_pattern_o <= 1'b0;
			regclr_o <= 1'b0;
			shift_prescale <= lab4_regs_pkg::SHIFT_PRESCALE_DEFAULT;
			prescale_o <= lab4_regs_pkg::READOUT_PRESCALE_DEFAULT;
			readout_empty_size_o <= '0;
			uw_data <= '0;
			uw_sel <= '0;
			go_q <= 1'b0;
			force_q <= 1'b0;
			force_count <= '0;
			not_test_pattern <= 1'b0;
			readout_fifo_rst_o <= 1'b0;
			readout_rst_o <= 1'b0;
		end else begin
			wb_ack_o <= wb_cyc_i & wb_stb_i;
			// strobes last a single cycle
			go_q <= 1'b0;
			force_q <= 1'b0;
			readout_fifo_rst_o <= 1'b0;
			readout_rst_o <= 1'b0;
			if (wb_write) begin
				case (word)
					lab4_regs_pkg::REG_CONTROL: begin
						reset_req <= wb_dat_i[lab4_regs_pkg::CTRL_RESET_REQ];
						runmode_req <= wb_dat_i[lab4_regs_pkg::CTRL_RUNMODE_REQ];
						readout_test_pattern_o <= wb_dat_i[lab4_regs_pkg::CTRL_TEST_PATTERN];
						regclr_o <= wb_dat_i[lab4_regs_pkg::CTRL_REGCLR];
					end
					lab4_regs_pkg::REG_SHIFT_PRESCALE:
						shift_prescale <= wb_dat_i[lab4_pkg::PRESCALE_WIDTH-1:0];
					lab4_regs_pkg::REG_READOUT_PRESCALE:
						prescale_o <= wb_dat_i[lab4_regs_pkg::READOUT_PRESCALE_WIDTH-1:0];
					lab4_regs_pkg::REG_USER_WRITE: begin
						uw_data <= wb_dat_i[DW-1:0];
						uw_sel <= wb_dat_i[lab4_regs_pkg::UW_SEL_LSB +: SEL_W];
						go_q <= wb_dat_i[lab4_regs_pkg::UW_REQUEST];
					end
					lab4_regs_pkg::REG_TRIGGER: begin
						// only this register honours byte enables
						if (wb_sel_i[0])
							force_q <= wb_dat_i[lab4_regs_pkg::TRIG_FORCE];
						if (wb_sel_i[1])
							force_count <= wb_dat_i[lab4_regs_pkg::TRIG_COUNT_LSB +: FCW];
					end
					lab4_regs_pkg::REG_READOUT: begin
						readout_fifo_rst_o <= wb_dat_i[lab4_regs_pkg::RD_FIFO_RST];
						readout_rst_o <= wb_dat_i[lab4_regs_pkg::RD_RST];
						not_test_pattern <= wb_dat_i[lab4_regs_pkg::RD_NOT_TEST_PATTERN];
					end
					lab4_regs_pkg::REG_EMPTY_THRESHOLD:
						readout_empty_size_o <= wb_dat_i[lab4_regs_pkg::EMPTY_SIZE_WIDTH-1:0];
					default: ;
				endcase
			end
		end
	end

	assign serial_cmd.go = go_q;
	assign serial_cmd.data = uw_data;
	assign serial_cmd.sel = uw_sel;
	assign serial_cmd.prescale = shift_prescale;
	assign ro_seq.force_req = force_q;
	assign ro_seq.force_count = force_count;

	//////////////////////////////////////////////////////////////////////
	// readback mux
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		wb_dat_o = '0;
		case (word)
			lab4_regs_pkg::REG_CONTROL: begin
				wb_dat_o[lab4_regs_pkg::CTRL_RESET_REQ] = reset_req;
				wb_dat_o[lab4_regs_pkg::CTRL_RUNMODE_REQ] = runmode_req;
				wb_dat_o[lab4_regs_pkg::CTRL_TEST_PATTERN] = readout_test_pattern_o;
				wb_dat_o[lab4_regs_pkg::CTRL_REGCLR] = regclr_o;
			end
			lab4_regs_pkg::REG_SHIFT_PRESCALE:
				wb_dat_o[lab4_pkg::PRESCALE_WIDTH-1:0] = shift_prescale;
			lab4_regs_pkg::REG_READOUT_PRESCALE:
				wb_dat_o[lab4_regs_pkg::READOUT_PRESCALE_WIDTH-1:0] = prescale_o;
			lab4_regs_pkg::REG_USER_WRITE: begin
				wb_dat_o[DW-1:0] = uw_data;
				wb_dat_o[lab4_regs_pkg::UW_SEL_LSB +: SEL_W] = uw_sel;
				// busy also covers the cycle the go strobe is in flight
				wb_dat_o[lab4_regs_pkg::UW_REQUEST] = serial_cmd.busy | go_q;
			end
			lab4_regs_pkg::REG_TRIGGER:
				wb_dat_o[lab4_regs_pkg::TRIG_COUNT_LSB +: FCW] = force_count;
			lab4_regs_pkg::REG_READOUT: begin
				wb_dat_o[lab4_regs_pkg::RD_DATA_AVAIL] = ~&readout_fifo_empty_i;
				wb_dat_o[lab4_regs_pkg::RD_NOT_TEST_PATTERN] = not_test_pattern;
				wb_dat_o[lab4_regs_pkg::RD_FORCE_ACTIVE] = ro_seq.active;
				wb_dat_o[lab4_regs_pkg::RD_PENDING] = ro_seq.pending;
				wb_dat_o[lab4_regs_pkg::RD_EMPTY_LSB +: NUM_LABS] = readout_fifo_empty_i;
			end
			lab4_regs_pkg::REG_EMPTY_THRESHOLD:
				wb_dat_o[lab4_regs_pkg::EMPTY_SIZE_WIDTH-1:0] = readout_empty_size_o;
			default: ;
		endcase
	end

endmodule

// ==== rtl/lab4_serial_writer.sv ====
`timescale 1ns/100ps

module lab4_serial_writer #(
	parameter int NUM_LABS = 4
) (
	input  logic clk_i,
	input  logic arst_n_i,
	input  logic [NUM_LABS-1:0] lab4_channel_disable_i,
	serial_cmd_if.writer serial_cmd,
	output logic [NUM_LABS-1:0] sin_o,
	output logic sclk_o,
	output logic [NUM_LABS-1:0] pclk_o
);
	localparam int DW = lab4_pkg::LAB4_REG_WIDTH;
	localparam int PW = lab4_pkg::PRESCALE_WIDTH;
	localparam int SEL_W = lab4_pkg::lab4_sel_width(NUM_LABS);
	localparam int BW = $clog2(DW);

	typedef enum logic [1:0] {st_idle, st_shift, st_latch} state_t;

	state_t state;
	logic [PW-1:0] pre_cnt;
	logic [BW-1:0] bit_cnt;
	logic sclk_high;
	logic [DW-1:0] shift_q;
	logic [SEL_W-1:0] sel_q;
	logic [PW-1:0] pre_q;
	logic [NUM_LABS-1:0] lab_hit;
	logic step;

	// one prescale period has elapsed
	assign step = (pre_cnt == pre_q);

	// each bit is a low half then a high half, then one pclk period
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state <= st_idle;
			pre_cnt <= '0;
			bit_cnt <= '0;
			sclk_high <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					pre_cnt <= '0;
					bit_cnt <= '0;
					sclk_high <= 1'b0;
					if (serial_cmd.go)
						state <= st_shift;
				end
				st_shift: begin
					pre_cnt <= step ? '0 : pre_cnt + 1'b1;
					if (step) begin
						sclk_high <= ~sclk_high;
						if (sclk_high) begin
							bit_cnt <= bit_cnt + 1'b1;
							if (bit_cnt == BW'(DW - 1))
								state <= st_latch;
						end
					end
				end
				default: begin
					pre_cnt <= step ? '0 : pre_cnt + 1'b1;
					if (step)
						state <= st_idle;
				end
			endcase
		end
	end

	// word, select and prescale are captured on go
	always_ff @(posedge clk_i) begin
		if (state == st_idle && serial_cmd.go) begin
			shift_q <= serial_cmd.data;
			sel_q <= serial_cmd.sel;
			pre_q <= serial_cmd.prescale;
		end else if (state == st_shift && step && sclk_high) begin
			shift_q <= {shift_q[DW-2:0], 1'b0};
		end
	end

	always_comb begin
		for (int i = 0; i < NUM_LABS; i++)
			lab_hit[i] = (&sel_q) || (sel_q == SEL_W'(i));
	end

	assign serial_cmd.busy = (state != st_idle);
	assign sclk_o = (state == st_shift) && sclk_high;
	assign sin_o = (state == st_shift) ? (lab_hit & {NUM_LABS{shift_q[DW-1]}}) : '0;
	assign pclk_o = (state == st_latch) ? (lab_hit & ~lab4_channel_disable_i) : '0;

endmodule

// ==== rtl/lab4_readout_seq.sv ====
`timescale 1ns/100ps

module lab4_readout_seq (
	input  logic clk_i,
	input  logic arst_n_i,
	input  logic complete_i,
	readout_seq_if.seq ro_seq,
	output logic readout_o
);
	localparam int FCW = lab4_regs_pkg::FORCE_COUNT_WIDTH;

	logic pending_q;
	logic active_q;
	logic more_q;
	// readouts finished so far in this sequence
	logic [FCW-1:0] done_cnt;

	//////////////////////////////////////////////////////////////////////
	// force sequence
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pending_q <= 1'b0;
			active_q <= 1'b0;
			more_q <= 1'b0;
			readout_o <= 1'b0;
			done_cnt <= '0;
		end else begin
			readout_o <= 1'b0;
			more_q <= 1'b0;
			if (ro_seq.force_req) begin
				// a new force restarts the count
				active_q <= 1'b1;
				pending_q <= 1'b1;
				readout_o <= 1'b1;
				done_cnt <= '0;
			end else if (more_q) begin
				pending_q <= 1'b1;
				readout_o <= 1'b1;
			end else if (active_q && pending_q && complete_i) begin
				pending_q <= 1'b0;
				if (done_cnt == ro_seq.force_count) begin
					active_q <= 1'b0;
				end else begin
					done_cnt <= done_cnt + 1'b1;
					more_q <= 1'b1;
				end
			end
		end
	end

	assign ro_seq.pending = pending_q;
	assign ro_seq.active = active_q;

endmodule

// ==== rtl/lab4_ctrl_top.sv ====
`timescale 1ns/100ps

module lab4_ctrl_top #(
	parameter int NUM_LABS = 4
) (
	input  logic clk_i,
	input  logic arst_n_i,
	// wishbone slave
	input  logic wb_cyc_i,
	input  logic wb_stb_i,
	input  logic wb_we_i,
	input  logic [6:0] wb_adr_i,
	input  logic [3:0] wb_sel_i,
	input  logic [31:0] wb_dat_i,
	output logic [31:0] wb_dat_o,
	output logic wb_ack_o,
	// readout side
	input  logic complete_i,
	input  logic [NUM_LABS-1:0] readout_fifo_empty_i,
	input  logic [NUM_LABS-1:0] lab4_channel_disable_i,
	output logic readout_o,
	output logic readout_fifo_rst_o,
	output logic readout_rst_o,
	output logic readout_test_pattern_o,
	output logic [lab4_regs_pkg::EMPTY_SIZE_WIDTH-1:0] readout_empty_size_o,
	output logic [lab4_regs_pkg::READOUT_PRESCALE_WIDTH-1:0] prescale_o,
	// LAB4 pins
	output logic regclr_o,
	output logic [NUM_LABS-1:0] sin_o,
	output logic sclk_o,
	output logic [NUM_LABS-1:0] pclk_o
);

	serial_cmd_if #(.NUM_LABS(NUM_LABS)) serial_cmd ();
	readout_seq_if ro_seq ();

	lab4_reg_ctrl #(.NUM_LABS(NUM_LABS)) u_reg_ctrl (
		.clk_i(clk_i),
		.arst_n_i(arst_n_i),
		.wb_cyc_i(wb_cyc_i),
		.wb_stb_i(wb_stb_i),
		.wb_we_i(wb_we_i),
		.wb_adr_i(wb_adr_i),
		.wb_sel_i(wb_sel_i),
		.wb_dat_i(wb_dat_i),
		.wb_dat_o(wb_dat_o),
		.wb_ack_o(wb_ack_o),
		.readout_fifo_empty_i(readout_fifo_empty_i),
		.regclr_o(regclr_o),
		.readout_test_pattern_o(readout_test_pattern_o),
		.readout_fifo_rst_o(readout_fifo_rst_o),
		.readout_rst_o(readout_rst_o),
		.readout_empty_size_o(readout_empty_size_o),
		.prescale_o(prescale_o),
		.serial_cmd(serial_cmd.ctrl),
		.ro_seq(ro_seq.ctrl)
	);

	lab4_serial_writer #(.NUM_LABS(NUM_LABS)) u_serial_writer (
		.clk_i(clk_i),
		.arst_n_i(arst_n_i),
		.lab4_channel_disable_i(lab4_channel_disable_i),
		.serial_cmd(serial_cmd.writer),
		.sin_o(sin_o),
		.sclk_o(sclk_o),
		.pclk_o(pclk_o)
	);

	lab4_readout_seq u_readout_seq (
		.clk_i(clk_i),
		.arst_n_i(arst_n_i),
		.complete_i(complete_i),
		.ro_seq(ro_seq.seq),
		.readout_o(readout_o)
	);

endmodule

// ==== bench/lab4_ctrl_clkgen.sv ====
`timescale 1ns/100ps

module lab4_ctrl_clkgen #(
	parameter int PERIOD_NS = 4,
	parameter int RESET_CYCLES = 10
) (
	output logic clk_o,
	output logic arst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
	end

	// release lands just after an edge, away from the sampling point
	initial begin
		arst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		#1 arst_n_o = 1'b1;
	end

endmodule

// ==== bench/lab4_ctrl_tb.sv ====
`timescale 1ns/100ps

module lab4_ctrl_tb;

	localparam int CLK_PERIOD = 4;
	localparam int ACK_LIMIT = 8;
	localparam int SERIAL_ROWS = 4;
	localparam int FORCE_ROWS = 3;
	localparam int MAX_FORCE_COUNT = 5;
	localparam int MAX_DELAY = 9;
	localparam int POLL_LIMIT = 49 * 256;
	// worst case serial word at prescale 255, plus every readout at the longest delay
	localparam int WATCHDOG_CYCLES = SERIAL_ROWS * 49 * 256
		+ FORCE_ROWS * (MAX_FORCE_COUNT + 1) * (MAX_DELAY + 4) + 4000;

	typedef struct packed {
		logic [4:0] word;
		logic [31:0] rdata;
	} rst_row_t;
	typedef struct packed {
		logic [4:0] word;
		logic [31:0] wdata;
		logic [3:0] sel;
		logic [31:0] rdata;
	} reg_row_t;
	typedef struct packed {
		logic [2:0] sel;
		logic [23:0] data;
		logic [3:0] dis;
		logic [7:0] pre;
	} ser_row_t;
	typedef struct packed {
		logic [3:0] empty;
		logic [31:0] rdata;
	} fifo_row_t;

	//////////////////////////////////////////////////////////////////////
	// stimulus and expected values
	//////////////////////////////////////////////////////////////////////
	rst_row_t rst_tab [7] = '{
		'{lab4_regs_pkg::REG_CONTROL, 32'h0}, '{lab4_regs_pkg::REG_SHIFT_PRESCALE, 32'h1},
		'{lab4_regs_pkg::REG_READOUT_PRESCALE, 32'h1}, '{lab4_regs_pkg::REG_USER_WRITE, 32'h0},
		'{lab4_regs_pkg::REG_TRIGGER, 32'h0}, '{lab4_regs_pkg::REG_READOUT, 32'h0000_0f00},
		'{lab4_regs_pkg::REG_EMPTY_THRESHOLD, 32'h0}};
	reg_row_t reg_tab [11] = '{
		'{lab4_regs_pkg::REG_CONTROL, 32'h0001_8003, 4'hf, 32'h0001_8003},
		'{lab4_regs_pkg::REG_CONTROL, 32'hffff_7ffd, 4'hf, 32'h0001_0001},
		'{lab4_regs_pkg::REG_SHIFT_PRESCALE, 32'habcd_ef05, 4'hf, 32'h0000_0005},
		'{lab4_regs_pkg::REG_READOUT_PRESCALE, 32'h0000_00f7, 4'hf, 32'h0000_0007},
		'{lab4_regs_pkg::REG_EMPTY_THRESHOLD, 32'h0000_f6a5, 4'hf, 32'h0000_02a5},
		'{lab4_regs_pkg::REG_TRIGGER, 32'h0000_3400, 4'b0010, 32'h0000_3400},
		'{lab4_regs_pkg::REG_TRIGGER, 32'h0000_5500, 4'b0001, 32'h0000_3400},
		'{lab4_regs_pkg::REG_TRIGGER, 32'hffff_0000, 4'b1100, 32'h0000_3400},
		'{lab4_regs_pkg::REG_TRIGGER, 32'h0000_0000, 4'b0010, 32'h0000_0000},
		'{lab4_regs_pkg::REG_READOUT, 32'h0000_0010, 4'hf, 32'h0000_0f10},
		'{lab4_regs_pkg::REG_CONTROL, 32'h0000_0000, 4'hf, 32'h0000_0000}};
	// select 7 addresses every LAB
	ser_row_t ser_tab [SERIAL_ROWS] = '{
		'{3'd0, 24'ha5c396, 4'b0000, 8'd0}, '{3'd2, 24'h5a0f31, 4'b0100, 8'd1},
		'{3'd7, 24'hc0ffee, 4'b0010, 8'd5}, '{3'd3, 24'h123456, 4'b0000, 8'd2}};
	int force_tab [FORCE_ROWS] = '{0, 2, 5};
	fifo_row_t fifo_tab [5] = '{
		'{4'hf, 32'h0000_0f00}, '{4'h0, 32'h0000_0008}, '{4'h5, 32'h0000_0508},
		'{4'he, 32'h0000_0e08}, '{4'h7, 32'h0000_0708}};

	logic clk, arst_n;
	logic wb_cyc, wb_stb, wb_we, wb_ack, complete;
	logic [6:0] wb_adr;
	logic [3:0] wb_sel, fifo_empty, ch_disable, prescale, sin, pclk;
	logic [31:0] wb_dat_w, wb_dat_r;
	logic readout, fifo_rst, rd_rst, test_pattern, regclr, sclk;
	logic [9:0] empty_size;

	// monitor state, cleared by the main process between rows
	logic [23:0] rebuilt;
	logic [3:0] hit_mask, pclk_seen, sin_stray;
	logic sclk_prev;
	int cap_lab, cap_bits, fifo_rst_cycles, rd_rst_cycles, strobes;
	int errors, test_base, tests_run, tests_failed;
	integer seed = 32'h1497;
	string cur_test;

	lab4_ctrl_clkgen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(10)) clkgen (
		.clk_o(clk), .arst_n_o(arst_n));

	lab4_ctrl_top #(.NUM_LABS(4)) uut (
		.clk_i(clk), .arst_n_i(arst_n),
		.wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_adr_i(wb_adr),
		.wb_sel_i(wb_sel), .wb_dat_i(wb_dat_w), .wb_dat_o(wb_dat_r), .wb_ack_o(wb_ack),
		.complete_i(complete), .readout_fifo_empty_i(fifo_empty),
		.lab4_channel_disable_i(ch_disable), .readout_o(readout),
		.readout_fifo_rst_o(fifo_rst), .readout_rst_o(rd_rst),
		.readout_test_pattern_o(test_pattern), .readout_empty_size_o(empty_size),
		.prescale_o(prescale), .regclr_o(regclr), .sin_o(sin), .sclk_o(sclk), .pclk_o(pclk));

	task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			$display("** Error %s %s: expected 0x%h, actual 0x%h", cur_test, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_true(input string msg, input logic cond);
		assert (cond === 1'b1) else begin
			$display("error in %s: %s", cur_test, msg);
			errors++;
		end
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_base = errors;
	endtask

	task automatic end_test();
		tests_run++;
		if (errors != test_base) begin
			tests_failed++;
			$display("%-16s failed", cur_test);
		end else begin
			$display("%-16s ok", cur_test);
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	// single wishbone cycle, stb held until ack so read data is sampled with it
	task automatic bus_cycle(input logic we, input logic [4:0] word, input logic [31:0] wdata,
			input logic [3:0] sel, output logic [31:0] rdata);
		int waited;
		@(posedge clk);
		#1;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = {word, 2'b00};
		wb_sel = sel;
		wb_dat_w = wdata;
		waited = 0;
		do begin
			@(posedge clk);
			#1;
			waited++;
		end while (wb_ack !== 1'b1 && waited < ACK_LIMIT);
		check_true("wishbone ack never arrived", wb_ack);
		rdata = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic write_reg(input logic [4:0] word, input logic [31:0] data, input logic [3:0] sel);
		logic [31:0] rd_ignored;
		bus_cycle(1'b1, word, data, sel, rd_ignored);
	endtask

	task automatic read_reg(input logic [4:0] word, output logic [31:0] data);
		bus_cycle(1'b0, word, 32'h0, 4'hf, data);
	endtask

	// LAB pins and pulse outputs are sampled mid-cycle
	always @(negedge clk) begin
		if (sclk && !sclk_prev) begin
			rebuilt = {rebuilt[22:0], sin[cap_lab]};
			cap_bits++;
		end
		sclk_prev = sclk;
		pclk_seen = pclk_seen | pclk;
		sin_stray = sin_stray | (sin & ~hit_mask);
		if (fifo_rst)
			fifo_rst_cycles++;
		if (rd_rst)
			rd_rst_cycles++;
	end

	// readout responder answers each strobe after a random delay
	always @(negedge clk) begin
		if (readout) begin
			strobes++;
			repeat (2 + ({$random(seed)} % (MAX_DELAY - 1))) @(posedge clk);
			#1 complete = 1'b1;
			@(posedge clk);
			#1 complete = 1'b0;
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired, the run did not finish in time");
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		logic [31:0] rd;
		logic [15:0] exp_pins;
		int polls;
		logic seen_active, seen_pending;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_sel = '0;
		wb_dat_w = '0;
		complete = 1'b0;
		fifo_empty = 4'hf;
		ch_disable = '0;
		{rebuilt, hit_mask, pclk_seen, sin_stray, sclk_prev} = '0;
		{cap_lab, cap_bits, fifo_rst_cycles, rd_rst_cycles, strobes} = '0;
		{errors, test_base, tests_run, tests_failed} = '0;
		wait (arst_n === 1'b1);
		idle_cycles(1);

		start_test("reset state");
		check_value("prescale_o", 32'h1, prescale);
		check_value("readout_empty_size_o", 32'h0, empty_size);
		check_value("control pins", 32'h0,
			{pclk, sin, readout, fifo_rst, rd_rst, sclk, regclr, test_pattern});
		foreach (rst_tab[i]) begin
			read_reg(rst_tab[i].word, rd);
			check_value($sformatf("word %0d", rst_tab[i].word), rst_tab[i].rdata, rd);
		end
		end_test();

		///////////////////////////////////////////////////////////////////
		// register table, pins follow the written fields
		///////////////////////////////////////////////////////////////////
		exp_pins = {1'b0, 1'b0, 4'd1, 10'd0};
		foreach (reg_tab[i]) begin
			start_test($sformatf("regs row %0d", i));
			write_reg(reg_tab[i].word, reg_tab[i].wdata, reg_tab[i].sel);
			if (reg_tab[i].word == lab4_regs_pkg::REG_CONTROL)
				exp_pins[15:14] = reg_tab[i].wdata[16:15];
			if (reg_tab[i].word == lab4_regs_pkg::REG_READOUT_PRESCALE)
				exp_pins[13:10] = reg_tab[i].wdata[3:0];
			if (reg_tab[i].word == lab4_regs_pkg::REG_EMPTY_THRESHOLD)
				exp_pins[9:0] = reg_tab[i].wdata[9:0];
			check_value("pins", exp_pins, {regclr, test_pattern, prescale, empty_size});
			read_reg(reg_tab[i].word, rd);
			check_value("readback", reg_tab[i].rdata, rd);
			end_test();
		end

		foreach (ser_tab[i]) begin
			start_test($sformatf("serial row %0d", i));
			hit_mask = (ser_tab[i].sel == 3'd7) ? 4'hf : (4'b0001 << ser_tab[i].sel);
			cap_lab = (ser_tab[i].sel == 3'd7) ? 3 : ser_tab[i].sel;
			ch_disable = ser_tab[i].dis;
			{rebuilt, pclk_seen, sin_stray} = '0;
			cap_bits = 0;
			write_reg(lab4_regs_pkg::REG_SHIFT_PRESCALE, {24'h0, ser_tab[i].pre}, 4'hf);
			write_reg(lab4_regs_pkg::REG_USER_WRITE,
				{1'b1, 4'h0, ser_tab[i].sel, ser_tab[i].data}, 4'hf);
			polls = 0;
			do begin
				read_reg(lab4_regs_pkg::REG_USER_WRITE, rd);
				polls++;
			end while (rd[31] && polls < POLL_LIMIT);
			check_true("busy never cleared", !rd[31]);
			check_value("readback", {5'h0, ser_tab[i].sel, ser_tab[i].data}, rd);
			check_value("sclk edges", 32'd24, cap_bits);
			check_value("shifted word", ser_tab[i].data, rebuilt);
			check_value("pclk lanes", hit_mask & ~ser_tab[i].dis, pclk_seen);
			check_value("sin on other LABs", 32'h0, sin_stray);
			end_test();
		end

		///////////////////////////////////////////////////////////////////
		// forced trigger sequences
		///////////////////////////////////////////////////////////////////
		foreach (force_tab[i]) begin
			start_test($sformatf("force count %0d", force_tab[i]));
			strobes = 0;
			seen_active = 1'b0;
			seen_pending = 1'b0;
			write_reg(lab4_regs_pkg::REG_TRIGGER, {16'h0, 8'(force_tab[i]), 8'h02}, 4'b0011);
			polls = 0;
			do begin
				read_reg(lab4_regs_pkg::REG_READOUT, rd);
				polls++;
				seen_active = seen_active | rd[5];
				seen_pending = seen_pending | rd[7];
				check_true("pending reported outside a sequence", !rd[7] || rd[5]);
			end while (rd[5] && polls < POLL_LIMIT);
			check_true("active flag never seen", seen_active);
			check_true("pending flag never seen", seen_pending);
			check_true("sequence never ended", !rd[5]);
			check_value("pending at end", 32'h0, rd[7]);
			idle_cycles(4);
			check_value("readout strobes", force_tab[i] + 1, strobes);
			end_test();
		end

		start_test("reset pulses");
		fifo_rst_cycles = 0;
		rd_rst_cycles = 0;
		write_reg(lab4_regs_pkg::REG_READOUT, 32'h0000_0006, 4'hf);
		idle_cycles(3);
		check_value("fifo reset cycles", 32'd1, fifo_rst_cycles);
		check_value("readout reset cycles", 32'd1, rd_rst_cycles);
		end_test();

		foreach (fifo_tab[i]) begin
			start_test($sformatf("fifo row %0d", i));
			fifo_empty = fifo_tab[i].empty;
			read_reg(lab4_regs_pkg::REG_READOUT, rd);
			check_value("readout word", fifo_tab[i].rdata, rd);
			end_test();
		end

		$display("tests %0d, failed %0d, failing checks %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// ==== lab4_ctrl.f ====
rtl/lab4_pkg.sv
rtl/lab4_regs_pkg.sv
rtl/lab4_ifs.sv
rtl/lab4_reg_ctrl.sv
rtl/lab4_serial_writer.sv
rtl/lab4_readout_seq.sv
rtl/lab4_ctrl_top.sv
bench/lab4_ctrl_clkgen.sv
bench/lab4_ctrl_tb.sv

// ==== Bender.yml ====
package:
  name: lab4_ctrl

sources:
  - rtl/lab4_pkg.sv
  - rtl/lab4_regs_pkg.sv
  - rtl/lab4_ifs.sv
  - rtl/lab4_reg_ctrl.sv
  - rtl/lab4_serial_writer.sv
  - rtl/lab4_readout_seq.sv
  - rtl/lab4_ctrl_top.sv
  - target: test
    files:
      - bench/lab4_ctrl_clkgen.sv
      - bench/lab4_ctrl_tb.sv
